// File: source/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// machine word and internal memory size
`define CPU_WORD_W 16
`define CPU_MEM_AW 8

// continuation address of an accepted interrupt
`define CPU_IRQ_VECTOR 8'h40

// control panel register map
`define CPU_REG_CTRL   8'h00
`define CPU_REG_STATUS 8'h04
`define CPU_REG_MADDR  8'h08
`define CPU_REG_MDATA  8'h0C
`define CPU_REG_IC     8'h10
`define CPU_REG_R0     8'h20

`endif

// File: source/cpu_pkg.sv
`include "cpu_macros.svh"
`default_nettype none

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_MEM_AW-1:0] mem_addr_t;

	// 6-bit opcode field, anything not listed is illegal
	typedef enum logic [5:0] {
		AW  = 6'o20,
		SW  = 6'o22,
		OR  = 6'o24,
		NR  = 6'o26,
		ER  = 6'o30,
		LW  = 6'o50,
		TW  = 6'o51,
		RW  = 6'o54,
		UJ  = 6'o70,
		JZ  = 6'o71,
		HLT = 6'o73
	} opcode_e;

	typedef enum logic [3:0] {
		STOP,
		FETCH,
		FETCH_WAIT,
		ARG,
		ARG_WAIT,
		OPER,
		OPER_WAIT,
		EXEC,
		WRITE,
		CYCLE_END
	} cpu_state_e;

	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
	} flags_t;

	typedef struct packed {
		opcode_e op;
		logic [2:0] a;
		logic [2:0] b;
		logic [2:0] c;
		logic needs_arg;
		logic reads_mem;
		logic writes_mem;
		logic writes_reg;
		logic is_jump;
		logic is_halt;
		logic illegal;
	} decoded_t;

	typedef struct packed {
		word_t value;
		flags_t flags;
		logic flags_valid;
		logic reg_we;
		logic [2:0] reg_idx;
		logic mem_we;
		mem_addr_t mem_addr;
		logic jump;
		word_t jump_addr;
		logic halt;
	} exec_res_t;

	typedef struct packed {
		logic en;
		logic we;
		mem_addr_t addr;
		word_t wdata;
	} mem_port_t;

	typedef struct packed {
		logic en;
		logic is_ic;
		logic [2:0] idx;
		word_t data;
	} reg_wr_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// File: source/ir_decode.sv
`default_nettype none

module ir_decode
	import cpu_pkg::*;
(
	input word_t ir,
	output decoded_t dec
);

	// set for every legal instruction that takes the argument N
	logic uses_n;

	always_comb begin
		dec = '0;
		uses_n = 1'b1;

		// fields: op 15..10, bit 9 spare, A 8..6, B 5..3, C 2..0
		dec.op = opcode_e'(ir[15:10]);
		dec.a = ir[8:6];
		dec.b = ir[5:3];
		dec.c = ir[2:0];

		case (dec.op)
			LW, AW, SW, OR, NR, ER: begin
				dec.writes_reg = 1'b1;
			end
			TW: begin
				dec.reads_mem = 1'b1;
				dec.writes_reg = 1'b1;
			end
			RW: begin
				dec.writes_mem = 1'b1;
			end
			UJ, JZ: begin
				dec.is_jump = 1'b1;
			end
			HLT: begin
				dec.is_halt = 1'b1;
				uses_n = 1'b0;
			end
			default: begin
				// unknown code, no argument word is fetched
				dec.illegal = 1'b1;
				uses_n = 1'b0;
			end
		endcase

		// C=0 means N comes from the word after the instruction
		dec.needs_arg = uses_n & (dec.c == 3'd0);
	end

endmodule

`default_nettype wire

// File: source/cycle_control.sv
`default_nettype none

module cycle_control
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic stop,
	input logic ie_wr,
	input logic irq,
	input decoded_t dec,
	input exec_res_t exec_res,
	input word_t mem_rdata,
	input word_t ic,
	output mem_port_t cmem,
	output word_t ir,
	output word_t arg_word,
	output word_t oper_word,
	output logic exec_en,
	output logic commit,
	output logic irq_take,
	output logic ic_step,
	output logic run,
	output logic halted,
	output logic illegal,
	output logic ie
);

	cpu_state_e state;
	cpu_state_e state_nx;
	logic stop_req;
	logic oper_done;
	logic halt_pend;

	assign run = (state != STOP);
	assign halt_pend = exec_res.halt | dec.illegal;
	assign exec_en = (state == EXEC);
	assign commit = (state == WRITE);
	assign irq_take = (state == CYCLE_END) & irq & ie & ~halt_pend;

	// IC moves past the instruction word and past the argument word
	assign ic_step = (state == FETCH) | ((state == ARG) & dec.needs_arg);

	always_comb begin
		cmem = '0;
		case (state)
			FETCH: begin
				cmem.en = 1'b1;
				cmem.addr = mem_addr_t'(ic);
			end
			ARG: begin
				cmem.en = dec.needs_arg;
				cmem.addr = mem_addr_t'(ic);
			end
			OPER: begin
				cmem.en = 1'b1;
				cmem.addr = exec_res.mem_addr;
			end
			WRITE: begin
				// store of RW
				cmem.en = exec_res.mem_we;
				cmem.we = exec_res.mem_we;
				cmem.addr = exec_res.mem_addr;
				cmem.wdata = exec_res.value;
			end
			default: begin
				cmem = '0;
			end
		endcase
	end

	always_comb begin
		state_nx = state;
		case (state)
			STOP: begin
				if (start) begin
					state_nx = FETCH;
				end
			end
			FETCH: state_nx = FETCH_WAIT;
			FETCH_WAIT: state_nx = ARG;
			ARG: state_nx = dec.needs_arg ? ARG_WAIT : EXEC;
			ARG_WAIT: state_nx = EXEC;
			// first EXEC pass forms the address, second one uses the operand
			EXEC: state_nx = (dec.reads_mem & ~oper_done) ? OPER : WRITE;
			OPER: state_nx = OPER_WAIT;
			OPER_WAIT: state_nx = EXEC;
			WRITE: state_nx = CYCLE_END;
			CYCLE_END: state_nx = (halt_pend | stop_req | stop) ? STOP : FETCH;
			default: state_nx = STOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= STOP;
			stop_req <= 1'b0;
			oper_done <= 1'b0;
			halted <= 1'b0;
			illegal <= 1'b0;
			ie <= 1'b0;
		end else begin
			state <= state_nx;

			if (state_nx == STOP) begin
				stop_req <= 1'b0;
			end else if (stop & run) begin
				stop_req <= 1'b1;
			end

			if ((state == STOP) & start) begin
				halted <= 1'b0;
				illegal <= 1'b0;
			end else if ((state == CYCLE_END) & halt_pend) begin
				halted <= 1'b1;
				illegal <= dec.illegal;
			end

			if (state == FETCH) begin
				oper_done <= 1'b0;
			end else if (state == OPER_WAIT) begin
				oper_done <= 1'b1;
			end

			// interrupt entry drops the enable
			if (irq_take) begin
				ie <= 1'b0;
			end else if (ie_wr) begin
				ie <= 1'b1;
			end
		end
	end

	// read data is valid one cycle after the request
	always_ff @(posedge clk) begin
		if (state == FETCH_WAIT) begin
			ir <= mem_rdata;
		end
		if (state == ARG_WAIT) begin
			arg_word <= mem_rdata;
		end
		if (state == OPER_WAIT) begin
			oper_word <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: source/micro_execute.sv
`default_nettype none

module micro_execute
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic exec_en,
	input decoded_t dec,
	input word_t arg_word,
	input word_t oper_word,
	input word_t ra_data,
	input word_t rb_data,
	input word_t rc_data,
	input flags_t flags,
	output exec_res_t exec_res,
	output logic [2:0] rd_a,
	output logic [2:0] rd_b,
	output logic [2:0] rd_c
);

	localparam int MSB = $bits(word_t) - 1;

	word_t base;
	word_t n_arg;
	word_t alu;
	logic carry;
	logic ovf;
	exec_res_t res;

	assign rd_a = dec.a;
	assign rd_b = dec.b;
	assign rd_c = dec.c;

	// N = (next word or RC) + RB, B=0 adds nothing
	assign base = (dec.c == 3'd0) ? arg_word : rc_data;
	assign n_arg = base + ((dec.b != 3'd0) ? rb_data : '0);

	always_comb begin
		carry = 1'b0;
		ovf = 1'b0;
		alu = n_arg;
		case (dec.op)
			AW: begin
				{carry, alu} = {1'b0, ra_data} + {1'b0, n_arg};
				ovf = (ra_data[MSB] == n_arg[MSB]) & (alu[MSB] != ra_data[MSB]);
			end
			SW: begin
				// carry out here is the borrow
				{carry, alu} = {1'b0, ra_data} - {1'b0, n_arg};
				ovf = (ra_data[MSB] != n_arg[MSB]) & (alu[MSB] != ra_data[MSB]);
			end
			OR: alu = ra_data | n_arg;
			NR: alu = ra_data & n_arg;
			ER: alu = ra_data ^ n_arg;
			TW: alu = oper_word;
			RW: alu = ra_data;
			default: alu = n_arg;
		endcase
	end

	always_comb begin
		res = '0;
		res.value = alu;
		res.flags.z = (alu == '0);
		res.flags.m = alu[MSB];
		res.flags.v = ovf;
		res.flags.c = carry;
		res.flags_valid = dec.writes_reg;
		res.reg_we = dec.writes_reg;
		res.reg_idx = dec.a;
		res.mem_we = dec.writes_mem;
		res.mem_addr = mem_addr_t'(n_arg);
		res.jump = dec.is_jump & ((dec.op != JZ) | flags.z);
		res.jump_addr = n_arg;
		res.halt = dec.is_halt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exec_res <= '0;
		end else if (exec_en) begin
			exec_res <= res;
		end
	end

endmodule

`default_nettype wire

// File: source/result_writeback.sv
`include "cpu_macros.svh"
`default_nettype none

module result_writeback
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clear,
	input logic commit,
	input logic irq_take,
	input logic ic_step,
	input exec_res_t exec_res,
	input reg_wr_t reg_wr,
	input logic [2:0] rd_a,
	input logic [2:0] rd_b,
	input logic [2:0] rd_c,
	input logic [2:0] reg_rd_idx,
	output word_t ra_data,
	output word_t rb_data,
	output word_t rc_data,
	output word_t reg_rd_data,
	output word_t ic,
	output flags_t flags
);

	// slot 0 stays zero, R0 is never stored
	word_t regs [8];

	function automatic word_t read_reg(input logic [2:0] idx);
		return (idx == 3'd0) ? '0 : regs[idx];
	endfunction

	assign ra_data = read_reg(rd_a);
	assign rb_data = read_reg(rd_b);
	assign rc_data = read_reg(rd_c);
	assign reg_rd_data = read_reg(reg_rd_idx);

	always_ff @(posedge clk) begin
		if (rst | clear) begin
			ic <= '0;
			flags <= '0;
		end else begin
			if (ic_step) begin
				ic <= ic + 1'b1;
			end
			if (reg_wr.en & reg_wr.is_ic) begin
				ic <= reg_wr.data;
			end
			if (commit) begin
				if (exec_res.flags_valid) begin
					flags <= exec_res.flags;
				end
				if (exec_res.jump) begin
					ic <= exec_res.jump_addr;
				end
			end
			if (irq_take) begin
				ic <= word_t'(`CPU_IRQ_VECTOR);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (reg_wr.en & ~reg_wr.is_ic & (reg_wr.idx != 3'd0)) begin
				regs[reg_wr.idx] <= reg_wr.data;
			end
			if (commit & exec_res.reg_we & (exec_res.reg_idx != 3'd0)) begin
				regs[exec_res.reg_idx] <= exec_res.value;
			end
			// return address for the interrupt routine
			if (irq_take) begin
				regs[7] <= ic;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/word_memory.sv
`default_nettype none

module word_memory
	import cpu_pkg::*;
(
	input logic clk,
	input mem_port_t cport,
	input mem_port_t pport,
	output word_t crdata,
	output word_t prdata
);

	word_t mem [2**$bits(mem_addr_t)];

	always_ff @(posedge clk) begin
		if (pport.en & pport.we) begin
			mem[pport.addr] <= pport.wdata;
		end
		// processor write comes last, so it wins on the same address
		if (cport.en & cport.we) begin
			mem[cport.addr] <= cport.wdata;
		end
		if (cport.en) begin
			crdata <= mem[cport.addr];
		end
		if (pport.en) begin
			prdata <= mem[pport.addr];
		end
	end

endmodule

`default_nettype wire

// File: source/panel_apb.sv
`include "cpu_macros.svh"
`default_nettype none

module panel_apb
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input apb_req_t apb_req,
	input logic run,
	input logic halted,
	input logic illegal,
	input logic ie,
	input flags_t flags,
	input word_t ic,
	input word_t reg_rd_data,
	input word_t pmem_rdata,
	output apb_rsp_t apb_rsp,
	output logic start,
	output logic stop,
	output logic clear,
	output logic ie_wr,
	output reg_wr_t reg_wr,
	output logic [2:0] reg_rd_idx,
	output mem_port_t pmem
);

	mem_addr_t maddr;
	logic rd_pend;
	logic access;
	logic wr_acc;
	logic sel_ctrl;
	logic sel_status;
	logic sel_maddr;
	logic sel_mdata;
	logic sel_ic;
	logic sel_reg;
	logic err;
	logic mem_rd;
	logic done;

	assign access = apb_req.psel & apb_req.penable;

	assign sel_ctrl = (apb_req.paddr == `CPU_REG_CTRL);
	assign sel_status = (apb_req.paddr == `CPU_REG_STATUS);
	assign sel_maddr = (apb_req.paddr == `CPU_REG_MADDR);
	assign sel_mdata = (apb_req.paddr == `CPU_REG_MDATA);
	assign sel_ic = (apb_req.paddr == `CPU_REG_IC);
	// R0..R7 at 0x20..0x3C, word aligned
	assign sel_reg = ((apb_req.paddr & 8'hE3) == `CPU_REG_R0);

	// unmapped, or machine state touched while running
	assign err = ~(sel_ctrl | sel_status | sel_maddr | sel_mdata | sel_ic | sel_reg)
		| (run & (sel_mdata | sel_ic | sel_reg));

	// memory read needs a wait state for the synchronous array
	assign mem_rd = sel_mdata & ~apb_req.pwrite & ~err;
	assign done = ~mem_rd | rd_pend;

	assign apb_rsp.pready = access & done;
	assign apb_rsp.pslverr = access & err;

	assign wr_acc = access & apb_req.pwrite & ~err;

	assign start = wr_acc & sel_ctrl & apb_req.pwdata[0];
	assign stop = wr_acc & sel_ctrl & apb_req.pwdata[1];
	assign clear = wr_acc & sel_ctrl & apb_req.pwdata[2];
	assign ie_wr = wr_acc & sel_ctrl & apb_req.pwdata[3];

	assign reg_wr.en = wr_acc & (sel_ic | sel_reg);
	assign reg_wr.is_ic = sel_ic;
	assign reg_wr.idx = apb_req.paddr[4:2];
	assign reg_wr.data = apb_req.pwdata[`CPU_WORD_W-1:0];
	assign reg_rd_idx = apb_req.paddr[4:2];

	assign pmem.en = access & sel_mdata & ~err & (apb_req.pwrite | ~rd_pend);
	assign pmem.we = apb_req.pwrite;
	assign pmem.addr = maddr;
	assign pmem.wdata = apb_req.pwdata[`CPU_WORD_W-1:0];

	always_comb begin
		apb_rsp.prdata = '0;
		if (sel_ctrl) begin
			apb_rsp.prdata = 32'({ie, 3'b000});
		end else if (sel_status) begin
			apb_rsp.prdata = 32'({flags, ie, illegal, halted, run});
		end else if (sel_maddr) begin
			apb_rsp.prdata = 32'(maddr);
		end else if (sel_mdata) begin
			apb_rsp.prdata = 32'(pmem_rdata);
		end else if (sel_ic) begin
			apb_rsp.prdata = 32'(ic);
		end else if (sel_reg) begin
			apb_rsp.prdata = 32'(reg_rd_data);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			maddr <= '0;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= access & mem_rd & ~rd_pend;
			if (wr_acc & sel_maddr) begin
				maddr <= apb_req.pwdata[`CPU_MEM_AW-1:0];
			end else if (access & sel_mdata & ~err & done) begin
				// window steps on every completed data access
				maddr <= maddr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`default_nettype none

module cpu_core
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input logic irq
);

	logic start;
	logic stop;
	logic clear;
	logic ie_wr;
	logic run;
	logic halted;
	logic illegal;
	logic ie;
	logic exec_en;
	logic commit;
	logic irq_take;
	logic ic_step;
	logic [2:0] reg_rd_idx;
	logic [2:0] rd_a;
	logic [2:0] rd_b;
	logic [2:0] rd_c;
	flags_t flags;
	word_t ic;
	word_t reg_rd_data;
	word_t ra_data;
	word_t rb_data;
	word_t rc_data;
	word_t ir;
	word_t arg_word;
	word_t oper_word;
	word_t cmem_rdata;
	word_t pmem_rdata;
	reg_wr_t reg_wr;
	mem_port_t cmem;
	mem_port_t pmem;
	decoded_t dec;
	exec_res_t exec_res;

	panel_apb i_panel_apb (.*);

	cycle_control i_cycle_control (.*, .mem_rdata(cmem_rdata));

	ir_decode i_ir_decode (.*);

	micro_execute i_micro_execute (.*);

	result_writeback i_result_writeback (.*);

	word_memory i_word_memory (
		.clk(clk),
		.cport(cmem),
		.pport(pmem),
		.crdata(cmem_rdata),
		.prdata(pmem_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/tb_cpu_core.sv
`include "cpu_macros.svh"
`default_nettype none

module tb_cpu_core
	import cpu_pkg::*;
;

	logic clk;
	logic rst;
	logic irq;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	int errors;
	int checks;
	logic [31:0] seed;
	word_t prog [$];

	cpu_core i_cpu_core (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.irq(irq)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// op 15..10, A 8..6, B 5..3, C 2..0
	function automatic word_t enc(input opcode_e op, input int a, input int b, input int c);
		return {op, 1'b0, 3'(a), 3'(b), 3'(c)};
	endfunction

	// result and flags of one instruction, packed as {flags, value}
	function automatic logic [19:0] alu_model(input opcode_e op, input word_t ra,
		input word_t n);
		int sum;
		int ssum;
		word_t r;
		flags_t f;
		f = '0;
		r = n;
		case (op)
			AW: begin
				sum = int'(ra) + int'(n);
				ssum = int'($signed(ra)) + int'($signed(n));
				r = word_t'(sum);
				// carry out of the 16-bit sum
				f.c = (sum > 65535);
				f.v = (ssum > 32767) || (ssum < -32768);
			end
			SW: begin
				sum = int'(ra) - int'(n);
				ssum = int'($signed(ra)) - int'($signed(n));
				r = word_t'(sum);
				// borrow
				f.c = (sum < 0);
				f.v = (ssum > 32767) || (ssum < -32768);
			end
			OR: r = ra | n;
			NR: r = ra & n;
			ER: r = ra ^ n;
			default: r = n;
		endcase
		f.z = (r == 16'h0000);
		f.m = r[15];
		return {f, r};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		@(posedge clk);
		#1;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		n = 0;
		@(negedge clk);
		while (!apb_rsp.pready && n < 20) begin
			n++;
			@(negedge clk);
		end
		if (!apb_rsp.pready) begin
			errors++;
			$display("APB transfer to address %h never completed", addr);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check("pslverr", 32'(err), 32'd0);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check("pslverr", 32'(err), 32'd0);
	endtask

	task automatic load_prog(input logic [7:0] addr);
		apb_write(`CPU_REG_MADDR, 32'(addr));
		foreach (prog[i]) begin
			apb_write(`CPU_REG_MDATA, 32'(prog[i]));
		end
	endtask

	task automatic wait_halt();
		logic [31:0] st;
		int n;
		n = 0;
		apb_read(`CPU_REG_STATUS, st);
		while (st[0] && n < 200) begin
			n++;
			apb_read(`CPU_REG_STATUS, st);
		end
		if (st[0]) begin
			errors++;
			$display("processor still running after %0d status polls", n);
		end
	endtask

	task automatic run_from_zero(input logic [31:0] ctrl);
		apb_write(`CPU_REG_IC, 32'd0);
		apb_write(`CPU_REG_CTRL, ctrl);
		wait_halt();
	endtask

	task automatic panel_access();
		logic [31:0] rd;
		logic err;
		word_t vals [4];
		apb_read(`CPU_REG_STATUS, rd);
		check("status after reset", rd, 32'd0);
		apb_write(`CPU_REG_MADDR, 32'h20);
		for (int i = 0; i < 4; i++) begin
			vals[i] = word_t'(lcg_next());
			apb_write(`CPU_REG_MDATA, 32'(vals[i]));
		end
		apb_write(`CPU_REG_MADDR, 32'h20);
		for (int i = 0; i < 4; i++) begin
			apb_read(`CPU_REG_MDATA, rd);
			check("mdata readback", rd, 32'(vals[i]));
		end
		apb_read(`CPU_REG_MADDR, rd);
		check("maddr", rd, 32'h24);
		apb_write(`CPU_REG_IC, 32'h1234);
		apb_read(`CPU_REG_IC, rd);
		check("ic", rd, 32'h1234);
		for (int i = 0; i < 8; i++) begin
			apb_write(8'(`CPU_REG_R0 + 4 * i), 32'(16'h1100 + i));
		end
		for (int i = 0; i < 8; i++) begin
			apb_read(8'(`CPU_REG_R0 + 4 * i), rd);
			check($sformatf("r%0d", i), rd, (i == 0) ? 32'd0 : 32'(16'h1100 + i));
		end
		apb_xfer(1'b0, 8'h14, 32'd0, rd, err);
		check("unmapped pslverr", 32'(err), 32'd1);
	endtask

	task automatic alu_ops();
		opcode_e ops [5];
		word_t x;
		word_t y;
		logic [19:0] exp;
		logic [31:0] rd;
		ops = '{AW, SW, OR, NR, ER};
		foreach (ops[k]) begin
			x = word_t'(lcg_next());
			y = word_t'(lcg_next() >> 8);
			prog = '{enc(LW, 1, 0, 0), x, enc(LW, 2, 0, 0), y,
				enc(ops[k], 1, 0, 2), enc(HLT, 0, 0, 0)};
			load_prog(8'h00);
			run_from_zero(32'h1);
			exp = alu_model(ops[k], x, y);
			apb_read(8'(`CPU_REG_R0 + 4), rd);
			check($sformatf("%s r1", ops[k].name()), rd, 32'(exp[15:0]));
			apb_read(`CPU_REG_STATUS, rd);
			check($sformatf("%s status", ops[k].name()), rd, 32'({exp[19:16], 4'b0010}));
		end
	endtask

	task automatic addressing_modes();
		word_t v;
		logic [31:0] rd;
		v = word_t'(lcg_next());
		prog = '{enc(LW, 2, 0, 0), 16'h0080, enc(LW, 4, 0, 0), 16'h0030,
			enc(TW, 1, 0, 0), 16'h0080, enc(TW, 3, 0, 2), enc(TW, 5, 4, 0), 16'h0050,
			enc(RW, 1, 0, 4), enc(RW, 3, 0, 0), 16'h0090, enc(RW, 5, 4, 0), 16'h0062,
			enc(HLT, 0, 0, 0)};
		load_prog(8'h00);
		apb_write(`CPU_REG_MADDR, 32'h80);
		apb_write(`CPU_REG_MDATA, 32'(v));
		run_from_zero(32'h1);
		for (int i = 1; i <= 5; i += 2) begin
			apb_read(8'(`CPU_REG_R0 + 4 * i), rd);
			check($sformatf("tw r%0d", i), rd, 32'(v));
		end
		apb_write(`CPU_REG_MADDR, 32'h30);
		apb_read(`CPU_REG_MDATA, rd);
		check("rw register arg", rd, 32'(v));
		apb_write(`CPU_REG_MADDR, 32'h90);
		apb_read(`CPU_REG_MDATA, rd);
		check("rw next word", rd, 32'(v));
		apb_read(`CPU_REG_MDATA, rd);
		apb_read(`CPU_REG_MDATA, rd);
		check("rw b-modified", rd, 32'(v));
	endtask

	task automatic jump_paths();
		logic [31:0] rd;
		word_t exp_r [8];
		exp_r = '{0, 0, 0, 0, 5, 7, 0, 0};
		apb_write(`CPU_REG_CTRL, 32'h4);
		prog = '{enc(UJ, 0, 0, 0), 16'd4, enc(LW, 1, 0, 0), 16'd1,
			enc(LW, 2, 0, 0), 16'd0, enc(JZ, 0, 0, 0), 16'd10, enc(LW, 3, 0, 0), 16'd1,
			enc(LW, 4, 0, 0), 16'd5, enc(JZ, 0, 0, 0), 16'd16, enc(LW, 5, 0, 0), 16'd7,
			enc(HLT, 0, 0, 0)};
		load_prog(8'h00);
		run_from_zero(32'h1);
		for (int i = 1; i < 6; i++) begin
			apb_read(8'(`CPU_REG_R0 + 4 * i), rd);
			check($sformatf("jump r%0d", i), rd, 32'(exp_r[i]));
		end
		apb_read(`CPU_REG_IC, rd);
		check("ic after hlt", rd, 32'd17);
	endtask

	task automatic halt_conditions();
		logic [31:0] rd;
		logic err;
		apb_write(`CPU_REG_CTRL, 32'h4);
		prog = '{16'hFC00};
		load_prog(8'h00);
		run_from_zero(32'h1);
		apb_read(`CPU_REG_STATUS, rd);
		check("illegal status", rd & 32'h7, 32'h6);
		prog = '{enc(UJ, 0, 0, 0), 16'd0};
		load_prog(8'h00);
		apb_write(`CPU_REG_IC, 32'd0);
		apb_write(`CPU_REG_CTRL, 32'h1);
		repeat (10) @(posedge clk);
		apb_read(`CPU_REG_STATUS, rd);
		check("run in loop", rd & 32'h7, 32'h1);
		apb_xfer(1'b0, `CPU_REG_MDATA, 32'd0, rd, err);
		check("mdata while running pslverr", 32'(err), 32'd1);
		apb_write(`CPU_REG_CTRL, 32'h2);
		wait_halt();
		apb_read(`CPU_REG_STATUS, rd);
		check("status after stop", rd & 32'h7, 32'h0);
	endtask

	task automatic interrupt_entry();
		logic [31:0] rd;
		prog = '{enc(UJ, 0, 0, 0), 16'h0010};
		load_prog(8'h00);
		prog = '{enc(UJ, 0, 0, 0), 16'h0010};
		load_prog(8'h10);
		prog = '{enc(HLT, 0, 0, 0)};
		load_prog(`CPU_IRQ_VECTOR);
		apb_write(`CPU_REG_IC, 32'd0);
		apb_write(`CPU_REG_CTRL, 32'h9);
		repeat (20) @(posedge clk);
		#1;
		irq = 1'b1;
		wait_halt();
		irq = 1'b0;
		// entry happens at the end of the UJ, with IC back at L
		apb_read(8'(`CPU_REG_R0 + 28), rd);
		check("r7 return", rd, 32'h10);
		apb_read(`CPU_REG_IC, rd);
		check("ic after vector", rd, 32'(`CPU_IRQ_VECTOR) + 32'd1);
		apb_read(`CPU_REG_STATUS, rd);
		check("ie cleared", 32'(rd[3]), 32'd0);

		apb_write(8'(`CPU_REG_R0 + 28), 32'd0);
		apb_write(`CPU_REG_IC, 32'd0);
		apb_write(`CPU_REG_CTRL, 32'h1);
		@(posedge clk);
		#1;
		irq = 1'b1;
		repeat (40) @(posedge clk);
		apb_read(`CPU_REG_STATUS, rd);
		check("still running", rd & 32'h7, 32'h1);
		apb_write(`CPU_REG_CTRL, 32'h2);
		wait_halt();
		#1;
		irq = 1'b0;
		apb_read(8'(`CPU_REG_R0 + 28), rd);
		check("r7 untouched", rd, 32'd0);
		apb_read(`CPU_REG_IC, rd);
		check("ic in loop", rd, 32'h10);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		irq = 1'b0;
		apb_req = '0;
		errors = 0;
		checks = 0;
		seed = 32'hf49811d1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		panel_access();
		alu_ops();
		addressing_modes();
		jump_paths();
		halt_conditions();
		interrupt_entry();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/cpu_pkg.sv
source/ir_decode.sv
source/cycle_control.sv
source/micro_execute.sv
source/result_writeback.sv
source/word_memory.sv
source/panel_apb.sv
source/cpu_core.sv
testbench/tb_cpu_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_cpu_core \
	--Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0
